// File: verilog.f
+incdir+.
iso14443a_pkg.sv
rx_synchroniser.sv
sequence_decode.sv
frame_decode.sv
rx_byte_assembler.sv
iso14443a_rx.sv
tb_iso14443a_rx.sv

// File: tb_iso14443a_rx.sv
/*
 * testbench for the ISO/IEC 14443-A PICC receive front end
 * modified Miller encoder drives pause_n, assertions check every received byte
 */
`include "iso14443a_consts.svh"

module tb_iso14443a_rx;

    timeunit 1ns;
    timeprecision 100ps;

    // card clock halts for about this many ticks in each pause
    // so gaps between pause ends are shorter than the carrier time by this much
    localparam int CLK_STOP  = 48;
    // gap after an X that no legal PCD pattern can produce
    localparam int ERR_GAP   = 10;
    // data bits over all frames, then SOC, EOC, idle wait and spacing per frame
    localparam int DATA_BITS = 3 * 36 + 7 + 4 + 18;
    localparam int RUN_BITS  = DATA_BITS + 6 * 9 + 4 + 6;
    localparam int WATCHDOG  = RUN_BITS * `BIT_TICKS + 2048;

    logic       clk;
    logic       rst_n;
    logic       pause_n;
    logic       rx_idle;
    logic       rx_soc;
    logic [7:0] rx_data;
    logic       rx_data_valid;
    logic       rx_parity_error;
    logic [2:0] rx_last_bits;
    logic       rx_frame_done;
    logic       rx_frame_error;

    int seed = 90996;
    int cycle = 0;
    int errors = 0;
    int errors_before;
    int tests_run = 0;
    int tests_passed = 0;
    int soc_cnt;
    int done_cnt;
    int ferr_cnt;
    int last_end;
    logic quiet;

    // bits of the frame, PCD sequences, and pause end cycles
    logic                        bit_q[$];
    iso14443a_pkg::pcd_bit_seq_e seq_q[$];
    int                          end_q[$];
    // expected bytes as {parity error, last bits, data}
    logic [11:0]                 exp_q[$];
    logic [7:0]                  exp_data;
    logic [2:0]                  exp_last;
    logic                        exp_perr;
    logic                        exp_avail;

    iso14443a_rx u_iso14443a_rx (
        .clk             (clk),
        .rst_n           (rst_n),
        .pause_n         (pause_n),
        .rx_idle         (rx_idle),
        .rx_soc          (rx_soc),
        .rx_data         (rx_data),
        .rx_data_valid   (rx_data_valid),
        .rx_parity_error (rx_parity_error),
        .rx_last_bits    (rx_last_bits),
        .rx_frame_done   (rx_frame_done),
        .rx_frame_error  (rx_frame_error)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ------------------------------
    // reporting and expected data
    // ------------------------------

    task automatic note_error(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    task automatic value_error(input string name, input int got, input int want);
        errors++;
        $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
    endtask

    function automatic void load_head();
        exp_avail = (exp_q.size() > 0);
        if (exp_avail) begin
            {exp_perr, exp_last, exp_data} = exp_q[0];
        end
    endfunction

    // strobe counts and head of the expected queue
    always @(posedge clk) begin
        cycle++;
        if (rx_soc) begin
            soc_cnt++;
        end
        if (rx_frame_done) begin
            done_cnt++;
        end
        if (rx_frame_error) begin
            ferr_cnt++;
        end
        if (rx_data_valid && (exp_q.size() > 0)) begin
            void'(exp_q.pop_front());
            load_head();
        end
    end

    a_quiet_line: assert property (@(posedge clk) disable iff (!rst_n)
        quiet |-> rx_idle && !rx_soc && !rx_data_valid && !rx_frame_done && !rx_frame_error)
        else note_error("outputs moved while pause_n was held high");

    a_byte_expected: assert property (@(posedge clk) disable iff (!rst_n)
        rx_data_valid |-> exp_avail)
        else note_error("rx_data_valid pulsed with no byte outstanding");

    a_data: assert property (@(posedge clk) disable iff (!rst_n)
        rx_data_valid && exp_avail |-> rx_data == exp_data)
        else value_error("rx_data", $sampled(rx_data), $sampled(exp_data));

    a_parity: assert property (@(posedge clk) disable iff (!rst_n)
        rx_data_valid && exp_avail |-> rx_parity_error == exp_perr)
        else value_error("rx_parity_error", $sampled(rx_parity_error), $sampled(exp_perr));

    a_last_bits: assert property (@(posedge clk) disable iff (!rst_n)
        rx_data_valid && exp_avail |-> rx_last_bits == exp_last)
        else value_error("rx_last_bits", $sampled(rx_last_bits), $sampled(exp_last));

    // ------------------------------
    // frame building and encoding
    // ------------------------------

    function automatic int new_width();
        return 6 + ($unsigned($random(seed)) % 11);
    endfunction

    // LSB first, then the odd parity bit
    task automatic add_byte(input logic [7:0] data, input logic bad_parity);
        for (int i = 0; i < 8; i++) begin
            bit_q.push_back(data[i]);
        end
        bit_q.push_back(~(^data) ^ bad_parity);
        exp_q.push_back({bad_parity, 3'd0, data});
        load_head();
    endtask

    task automatic add_short(input logic [6:0] value);
        for (int i = 0; i < 7; i++) begin
            bit_q.push_back(value[i]);
        end
        exp_q.push_back({1'b0, 3'd7, 1'b0, value});
        load_head();
    endtask

    // SOC is Z, 1 is X, 0 is Y unless it follows a 0 or SOC
    task automatic encode_frame();
        logic after_zero;
        seq_q.delete();
        seq_q.push_back(iso14443a_pkg::SEQ_Z);
        after_zero = 1'b1;
        foreach (bit_q[i]) begin
            if (bit_q[i]) begin
                seq_q.push_back(iso14443a_pkg::SEQ_X);
            end else begin
                seq_q.push_back(after_zero ? iso14443a_pkg::SEQ_Z : iso14443a_pkg::SEQ_Y);
            end
            after_zero = !bit_q[i];
        end
        // EOC, a logical 0 and then Y
        seq_q.push_back(after_zero ? iso14443a_pkg::SEQ_Z : iso14443a_pkg::SEQ_Y);
        seq_q.push_back(iso14443a_pkg::SEQ_Y);
    endtask

    // X ends its pause half way into the bit time, Z at the start
    task automatic schedule_pauses();
        int base;
        int pauses;
        int pos;
        base = cycle + 40;
        pauses = 0;
        end_q.delete();
        foreach (seq_q[i]) begin
            if (seq_q[i] != iso14443a_pkg::SEQ_Y) begin
                pos = i * `BIT_TICKS;
                pos += (seq_q[i] == iso14443a_pkg::SEQ_X) ? `BIT_TICKS / 2 : 0;
                end_q.push_back(base + pos - CLK_STOP * pauses);
                pauses++;
            end
        end
    endtask

    task automatic send_pause(input int end_cycle, input int width);
        while (cycle < end_cycle - width) begin
            @(negedge clk);
        end
        pause_n = 1'b0;
        repeat (width) @(negedge clk);
        pause_n = 1'b1;
    endtask

    task automatic send_pauses(input int width);
        foreach (end_q[i]) begin
            send_pause(end_q[i], width);
        end
        last_end = end_q[$];
    endtask

    task automatic send_frame(input int width);
        encode_frame();
        schedule_pauses();
        send_pauses(width);
    endtask

    // idle comes back about two bit times after the last pause
    task automatic finish_frame(input logic check_gap);
        int n;
        n = 0;
        while (!rx_idle && (n < 6 * `BIT_TICKS)) begin
            @(negedge clk);
            n++;
        end
        if (!rx_idle) begin
            note_error("rx_idle did not return after the frame");
        end else if (check_gap) begin
            assert ((cycle - last_end >= `BIT_TICKS) && (cycle - last_end <= 3 * `BIT_TICKS))
                else note_error("rx_idle did not rise about two bit times after the last pause");
        end
        repeat (2 * `BIT_TICKS) @(negedge clk);
        bit_q.delete();
    endtask

    // ------------------------------
    // test bookkeeping
    // ------------------------------

    task automatic start_test();
        soc_cnt = 0;
        done_cnt = 0;
        ferr_cnt = 0;
        errors_before = errors;
    endtask

    task automatic end_test(input string name, input int want_soc, input int want_done,
                            input int want_ferr);
        assert (soc_cnt == want_soc) else value_error("rx_soc count", soc_cnt, want_soc);
        assert (done_cnt == want_done) else value_error("rx_frame_done count", done_cnt, want_done);
        assert (ferr_cnt == want_ferr) else value_error("rx_frame_error count", ferr_cnt, want_ferr);
        assert (exp_q.size() == 0) else note_error("expected bytes never arrived");
        exp_q.delete();
        load_head();
        tests_run++;
        if (errors == errors_before) begin
            tests_passed++;
            $display("test %0d, %s: ok", tests_run, name);
        end else begin
            $display("test %0d, %s: %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int width;
        int bad;
        pause_n = 1'b1;
        rst_n = 1'b0;
        quiet = 1'b0;
        load_head();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        start_test();
        quiet = 1'b1;
        repeat (4 * `BIT_TICKS) @(negedge clk);
        quiet = 1'b0;
        end_test("quiet line after reset", 0, 0, 0);

        start_test();
        width = new_width();
        for (int i = 0; i < 4; i++) begin
            add_byte(8'($random(seed)), 1'b0);
        end
        send_frame(width);
        finish_frame(1'b1);
        end_test("standard frame", 1, 1, 0);

        start_test();
        add_short(7'($random(seed)));
        send_frame(new_width());
        finish_frame(1'b1);
        end_test("short frame", 1, 1, 0);

        start_test();
        bad = $unsigned($random(seed)) % 4;
        for (int i = 0; i < 4; i++) begin
            add_byte(8'($random(seed)), i == bad);
        end
        send_frame(new_width());
        finish_frame(1'b1);
        end_test("parity error", 1, 1, 0);

        // bits 1 0 1 1, then a pause end too soon after the last X
        start_test();
        width = 6 + ($unsigned($random(seed)) % 3);
        for (int i = 0; i < 4; i++) begin
            bit_q.push_back(1'(4'b1101 >> i));
        end
        encode_frame();
        void'(seq_q.pop_back());
        void'(seq_q.pop_back());
        schedule_pauses();
        end_q.push_back(end_q[$] + ERR_GAP);
        send_pauses(width);
        finish_frame(1'b0);
        add_byte(8'($random(seed)), 1'b0);
        add_byte(8'($random(seed)), 1'b0);
        send_frame(width);
        finish_frame(1'b1);
        end_test("sequence error and recovery", 2, 1, 1);

        // zero right after SOC, long runs of both values
        start_test();
        add_byte(8'h00, 1'b0);
        add_byte(8'hff, 1'b0);
        add_byte(8'h0f, 1'b0);
        add_byte(8'hf0, 1'b0);
        send_frame(new_width());
        finish_frame(1'b1);
        end_test("runs of zeros and ones", 1, 1, 0);

        $display("%0d tests run, %0d passed, %0d errors", tests_run, tests_passed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: iso14443a_rx.sv
/*
 * ISO/IEC 14443-A PICC receive front end
 * pause_n in, decoded bytes with parity status out
 */
module iso14443a_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pause_n,
    output logic       rx_idle,
    output logic       rx_soc,
    output logic [7:0] rx_data,
    output logic       rx_data_valid,
    output logic       rx_parity_error,
    output logic [2:0] rx_last_bits,
    output logic       rx_frame_done,
    output logic       rx_frame_error
);

    logic                        rst_sync_n;
    logic                        pause_n_sync;
    iso14443a_pkg::pcd_bit_seq_e seq;
    logic                        seq_valid;
    logic                        bit_valid;
    logic                        bit_value;
    logic                        eoc;

    // async inputs into the clk domain
    rx_synchroniser u_rx_synchroniser (
        .clk          (clk),
        .rst_n        (rst_n),
        .pause_n      (pause_n),
        .rst_sync_n   (rst_sync_n),
        .pause_n_sync (pause_n_sync)
    );

    sequence_decode u_sequence_decode (
        .clk          (clk),
        .rst_n        (rst_sync_n),
        .pause_n_sync (pause_n_sync),
        .seq          (seq),
        .seq_valid    (seq_valid),
        .idle         (rx_idle)
    );

    // soc and frame_error also go straight out
    frame_decode u_frame_decode (
        .clk          (clk),
        .rst_n        (rst_sync_n),
        .seq          (seq),
        .seq_valid    (seq_valid),
        .idle         (rx_idle),
        .soc          (rx_soc),
        .bit_valid    (bit_valid),
        .bit_value    (bit_value),
        .eoc          (eoc),
        .frame_error  (rx_frame_error)
    );

    rx_byte_assembler u_rx_byte_assembler (
        .clk             (clk),
        .rst_n           (rst_sync_n),
        .soc             (rx_soc),
        .bit_valid       (bit_valid),
        .bit_value       (bit_value),
        .eoc             (eoc),
        .frame_error     (rx_frame_error),
        .rx_data         (rx_data),
        .rx_data_valid   (rx_data_valid),
        .rx_parity_error (rx_parity_error),
        .rx_last_bits    (rx_last_bits),
        .rx_frame_done   (rx_frame_done)
    );

endmodule

// File: rx_byte_assembler.sv
/*
 * receive byte assembler
 * LSB first shift register with odd parity check on every ninth bit
 * a short final byte is reported with its bit count
 */
module rx_byte_assembler (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       soc,
    input  logic       bit_valid,
    input  logic       bit_value,
    input  logic       eoc,
    input  logic       frame_error,
    output logic [7:0] rx_data,
    output logic       rx_data_valid,
    output logic       rx_parity_error,
    output logic [2:0] rx_last_bits,
    output logic       rx_frame_done
);

    logic [7:0] shift_reg;
    logic [3:0] bit_cnt;
    logic       full_byte;
    logic       partial_byte;

    // ninth bit of a byte is its parity
    assign full_byte    = bit_valid && (bit_cnt == 4'd8);
    // eoc with 1 to 7 data bits waiting
    assign partial_byte = eoc && (bit_cnt != 4'd0) && (bit_cnt < 4'd8);

    // ------------------------------
    // data path
    // ------------------------------

    always_ff @(posedge clk) begin
        if (bit_valid && !full_byte) begin
            shift_reg <= {bit_value, shift_reg[7:1]};
        end
        if (full_byte) begin
            rx_data <= shift_reg;
        end else if (partial_byte) begin
            // move the bits received down to bit 0
            rx_data <= shift_reg >> (4'd8 - bit_cnt);
        end
    end

    // ------------------------------
    // bit count and status
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt         <= 4'd0;
            rx_data_valid   <= 1'b0;
            rx_parity_error <= 1'b0;
            rx_last_bits    <= 3'd0;
            rx_frame_done   <= 1'b0;
        end else begin
            rx_data_valid <= full_byte || partial_byte;
            rx_frame_done <= eoc;
            if (full_byte) begin
                // data plus parity must hold an odd number of ones
                rx_parity_error <= ~(^{bit_value, shift_reg});
                rx_last_bits    <= 3'd0;
            end else if (partial_byte) begin
                rx_parity_error <= 1'b0;
                rx_last_bits    <= bit_cnt[2:0];
            end
            // a broken frame drops whatever was collected
            if (soc || eoc || frame_error || full_byte) begin
                bit_cnt <= 4'd0;
            end else if (bit_valid) begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // a bit on a frame boundary would be lost to the count clear
    a_bit_apart_from_edges: assert property (
        @(posedge clk) disable iff (!rst_n) bit_valid |-> !(soc || eoc || frame_error)
    ) else $error("data bit in the same cycle as soc, eoc or frame_error");

endmodule

// File: frame_decode.sv
/*
 * frame decoder
 * turns X, Y and Z sequences into SOC, data bits and EOC
 * one bit is held back so the EOC logical 0 can be dropped
 */
module frame_decode (
    input  logic                        clk,
    input  logic                        rst_n,
    input  iso14443a_pkg::pcd_bit_seq_e seq,
    input  logic                        seq_valid,
    input  logic                        idle,
    output logic                        soc,
    output logic                        bit_valid,
    output logic                        bit_value,
    output logic                        eoc,
    output logic                        frame_error
);

    iso14443a_pkg::frame_state_e state;
    iso14443a_pkg::pcd_bit_seq_e prev_seq;
    logic                        pending_value;
    logic                        is_data_seq;
    logic                        y_after_x;
    logic                        release_bit;
    logic                        load_bit;
    logic                        end_of_comm;
    logic                        bad_seq;

    // X and Z always carry a bit, Y only after an X
    assign is_data_seq = (seq == iso14443a_pkg::SEQ_X) || (seq == iso14443a_pkg::SEQ_Z);
    assign y_after_x   = (seq == iso14443a_pkg::SEQ_Y) && (prev_seq == iso14443a_pkg::SEQ_X);

    assign release_bit = seq_valid && (state == iso14443a_pkg::FRAME_DATA) &&
                         (is_data_seq || y_after_x);
    assign load_bit    = release_bit ||
                         (seq_valid && (state == iso14443a_pkg::FRAME_SOC) && is_data_seq);
    // Y after Y or Z, the pending bit is the logical 0 of EOC
    assign end_of_comm = seq_valid && (state == iso14443a_pkg::FRAME_DATA) &&
                         (seq == iso14443a_pkg::SEQ_Y) && !y_after_x;
    // a bare Y after SOC is not a frame
    assign bad_seq     = seq_valid &&
                         (((state == iso14443a_pkg::FRAME_SOC) && !is_data_seq) ||
                          ((state == iso14443a_pkg::FRAME_DATA) &&
                           (seq == iso14443a_pkg::SEQ_ERROR)));

    // ------------------------------
    // control
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= iso14443a_pkg::FRAME_IDLE;
            prev_seq    <= iso14443a_pkg::SEQ_Y;
            soc         <= 1'b0;
            bit_valid   <= 1'b0;
            eoc         <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            soc         <= 1'b0;
            bit_valid   <= release_bit;
            eoc         <= end_of_comm;
            frame_error <= bad_seq;
            if (seq_valid) begin
                prev_seq <= seq;
            end
            case (state)
                iso14443a_pkg::FRAME_IDLE: begin
                    if (seq_valid && (seq == iso14443a_pkg::SEQ_Z)) begin
                        soc   <= 1'b1;
                        state <= iso14443a_pkg::FRAME_SOC;
                    end
                end
                iso14443a_pkg::FRAME_SOC: begin
                    if (bad_seq) begin
                        state <= iso14443a_pkg::FRAME_WAIT_IDLE;
                    end else if (load_bit) begin
                        state <= iso14443a_pkg::FRAME_DATA;
                    end
                end
                iso14443a_pkg::FRAME_DATA: begin
                    if (bad_seq || end_of_comm) begin
                        state <= iso14443a_pkg::FRAME_WAIT_IDLE;
                    end
                end
                default: begin
                    // sequence_decode signals idle after its final Y
                    if (idle) begin
                        state <= iso14443a_pkg::FRAME_IDLE;
                    end
                end
            endcase
        end
    end

    // held bit and released bit
    always_ff @(posedge clk) begin
        if (release_bit) begin
            bit_value <= pending_value;
        end
        if (load_bit) begin
            pending_value <= (seq == iso14443a_pkg::SEQ_X);
        end
    end

    // the Y that raises idle must already have closed the frame
    a_idle_closes_frame: assert property (
        @(posedge clk) disable iff (!rst_n)
        idle && !seq_valid |->
            (state == iso14443a_pkg::FRAME_IDLE) || (state == iso14443a_pkg::FRAME_WAIT_IDLE)
    ) else $error("idle high while a frame is still open");

endmodule

// File: sequence_decode.sv
/*
 * modified Miller sequence decoder
 * times the gaps between pause ends and reports X, Y, Z or ERROR
 * two Ys in a row mean the PCD has stopped talking, so idle goes high
 */
`include "iso14443a_consts.svh"

module sequence_decode (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        pause_n_sync,
    output iso14443a_pkg::pcd_bit_seq_e seq,
    output logic                        seq_valid,
    output logic                        idle
);

    localparam logic [`SEQ_CNT_W-1:0] TMO_X     = `SEQ_TMO_X;
    localparam logic [`SEQ_CNT_W-1:0] TMO_Y     = `SEQ_TMO_Y;
    localparam logic [`SEQ_CNT_W-1:0] TMO_Z     = `SEQ_TMO_Z;
    localparam logic [`SEQ_CNT_W-1:0] TMO_ERR   = `SEQ_TMO_ERR;
    localparam logic [`SEQ_CNT_W-1:0] MIN_GAP   = `SEQ_MIN_GAP;
    localparam logic [`SEQ_CNT_W-1:0] Z_X_SPLIT = `SEQ_Z_X_SPLIT;
    localparam logic [`SEQ_CNT_W-1:0] Y_SPLIT   = `SEQ_Y_SPLIT;

    logic                        last_pause_n;
    logic                        pause_end;
    logic                        timeout;
    logic [`SEQ_CNT_W-1:0]       counter;
    iso14443a_pkg::pcd_bit_seq_e next_seq;

    // ------------------------------
    // pause end detect
    // ------------------------------

    // only the rising edge matters, the pause width varies with the PCD
    assign pause_end = !last_pause_n && pause_n_sync;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_pause_n <= 1'b1;
        end else begin
            last_pause_n <= pause_n_sync;
        end
    end

    // ------------------------------
    // interval classification
    // ------------------------------

    // sequence implied by a pause end, given the previous sequence
    always_comb begin
        case (seq)
            iso14443a_pkg::SEQ_X: begin
                // a Z straight after an X is not a legal pattern
                if (counter < MIN_GAP) begin
                    next_seq = iso14443a_pkg::SEQ_ERROR;
                end else begin
                    next_seq = iso14443a_pkg::SEQ_X;
                end
            end
            iso14443a_pkg::SEQ_Z: begin
                if (counter < MIN_GAP) begin
                    next_seq = iso14443a_pkg::SEQ_ERROR;
                end else if (counter < Z_X_SPLIT) begin
                    next_seq = iso14443a_pkg::SEQ_Z;
                end else begin
                    next_seq = iso14443a_pkg::SEQ_X;
                end
            end
            iso14443a_pkg::SEQ_Y: begin
                // no pause in the last bit time, so the counter started later
                if (counter < Y_SPLIT) begin
                    next_seq = iso14443a_pkg::SEQ_Z;
                end else begin
                    next_seq = iso14443a_pkg::SEQ_X;
                end
            end
            default: next_seq = iso14443a_pkg::SEQ_ERROR;
        endcase
    end

    // no pause seen within the window of the previous sequence
    always_comb begin
        case (seq)
            iso14443a_pkg::SEQ_X: timeout = (counter == TMO_X);
            iso14443a_pkg::SEQ_Y: timeout = (counter == TMO_Y);
            iso14443a_pkg::SEQ_Z: timeout = (counter == TMO_Z);
            default:              timeout = (counter == TMO_ERR);
        endcase
    end

    // ------------------------------
    // sequence output
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seq       <= iso14443a_pkg::SEQ_Y;
            seq_valid <= 1'b0;
            idle      <= 1'b1;
            counter   <= '0;
        end else begin
            seq_valid <= 1'b0;
            if (idle) begin
                // first pause after idle marks start of communication
                if (pause_end) begin
                    seq       <= iso14443a_pkg::SEQ_Z;
                    seq_valid <= 1'b1;
                    idle      <= 1'b0;
                    counter   <= `SEQ_CNT_W'(1);
                end
            end else if (pause_end) begin
                counter <= `SEQ_CNT_W'(1);
                // after an error, pauses only restart the recovery wait
                if (seq != iso14443a_pkg::SEQ_ERROR) begin
                    seq       <= next_seq;
                    seq_valid <= 1'b1;
                end
            end else if (timeout) begin
                seq       <= iso14443a_pkg::SEQ_Y;
                seq_valid <= 1'b1;
                counter   <= `SEQ_CNT_W'(1);
                // second Y in a row ends the exchange
                if (seq == iso14443a_pkg::SEQ_Y) begin
                    idle <= 1'b1;
                end
            end else begin
                counter <= counter + `SEQ_CNT_W'(1);
            end
        end
    end

    a_seq_valid_single: assert property (
        @(posedge clk) disable iff (!rst_n) seq_valid |=> !seq_valid
    ) else $error("seq_valid held for two cycles");

    // a timeout inside a pause would hide the pause end behind a Y
    a_no_y_in_pause: assert property (
        @(posedge clk) disable iff (!rst_n)
        seq_valid && (seq == iso14443a_pkg::SEQ_Y) |-> $past(pause_n_sync)
    ) else $error("Y timeout fired during a pause");

endmodule

// File: rx_synchroniser.sv
/*
 * receive input synchroniser
 * reset release and pause_n brought into the clk domain
 */
`include "iso14443a_consts.svh"

module rx_synchroniser (
    input  logic clk,
    input  logic rst_n,
    input  logic pause_n,
    output logic rst_sync_n,
    output logic pause_n_sync
);

    logic [`SYNC_STAGES-1:0] rst_pipe;
    logic [`SYNC_STAGES-1:0] pause_pipe;

    // asserts straight away, releases after SYNC_STAGES clocks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_pipe <= '0;
        end else begin
            rst_pipe <= {rst_pipe[`SYNC_STAGES-2:0], 1'b1};
        end
    end

    assign rst_sync_n = rst_pipe[`SYNC_STAGES-1];

    // pause_n idles high, so reset to "no pause"
    always_ff @(posedge clk or negedge rst_sync_n) begin
        if (!rst_sync_n) begin
            pause_pipe <= '1;
        end else begin
            pause_pipe <= {pause_pipe[`SYNC_STAGES-2:0], pause_n};
        end
    end

    assign pause_n_sync = pause_pipe[`SYNC_STAGES-1];

endmodule

// File: iso14443a_pkg.sv
/*
 * ISO/IEC 14443-A receive package
 * sequence and frame state types shared by the PICC receive blocks
 */
package iso14443a_pkg;

    // modified Miller sequences sent by the PCD
    // X has its pause half way through the bit time, Z at the start, Y has none
    typedef enum logic [1:0] {
        SEQ_X     = 2'd0,
        SEQ_Y     = 2'd1,
        SEQ_Z     = 2'd2,
        SEQ_ERROR = 2'd3
    } pcd_bit_seq_e;

    // frame decoder states
    typedef enum logic [1:0] {
        FRAME_IDLE      = 2'd0,
        FRAME_SOC       = 2'd1,
        FRAME_DATA      = 2'd2,
        FRAME_WAIT_IDLE = 2'd3
    } frame_state_e;

endpackage

// File: iso14443a_consts.svh
/*
 * ISO/IEC 14443-A PICC receive constants
 * synchroniser depth and modified Miller decode limits, in carrier ticks
 */
`ifndef ISO14443A_CONSTS_SVH
`define ISO14443A_CONSTS_SVH

// metastability stages on the async inputs
`define SYNC_STAGES 2

// pause interval counter width, must hold SEQ_TMO_ERR
`define SEQ_CNT_W 9

// timeouts that turn a missing pause into a Y, by previous sequence
`define SEQ_TMO_X 97
`define SEQ_TMO_Y 132
`define SEQ_TMO_Z 161
`define SEQ_TMO_ERR 384

// interval thresholds between pause ends
`define SEQ_MIN_GAP 16
`define SEQ_Z_X_SPLIT 96
`define SEQ_Y_SPLIT 64

// one bit time at fc/128
`define BIT_TICKS 128

`endif
